// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_vc_tile_array
FLIST     ?= tb.f
BUILD_DIR ?= obj_dir
BIN       ?= sim_bin
PASS_MSG  ?= TESTBENCH PASSED
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

$(BUILD_DIR)/$(BIN): $(shell cat $(FLIST) | grep -v '^+') vc_consts.svh
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) \
		-Mdir $(BUILD_DIR) -o $(BIN)

sim: $(BUILD_DIR)/$(BIN)
	@out="$$(./$(BUILD_DIR)/$(BIN))"; echo "$$out"; \
		echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: tb.f
+incdir+.
vc_pkg.sv
vc_reset_chain.sv
vc_ruche_buffer.sv
vc_tile.sv
vc_tile_array.sv
vc_tile_array_asserts.sv
tb_vc_tile_array.sv

// File: tb_vc_tile_array.sv
// tile row testbench
`timescale 1ns/100ps
`include "vc_consts.svh"

module tb_vc_tile_array
  import vc_pkg::*;
;

  localparam int T = `VC_NUM_TILES;
  localparam int R = `VC_RUCHE_FACTOR;
  localparam int W = `VC_BANK_WORDS;
  localparam int N_VER = 200;
  localparam int N_PKTS = 24;
  localparam int STIM = T * `VC_RESET_DEPTH + 2 * T * W + T * N_VER + 2 * R * N_PKTS * 16;
  localparam int TIMEOUT_CYCLES = 20 * STIM + 1000;

  logic                clk_i;
  logic                rst_n_i;
  wh_link_t [R-1:0]    wh_west_i;
  logic     [R-1:0]    wh_west_ready_o;
  wh_link_t [R-1:0]    wh_east_o;
  logic     [R-1:0]    wh_east_ready_i;
  ver_req_t [T-1:0]    ver_req_i;
  ver_rsp_t [T-1:0]    ver_rsp_o;

  logic [31:0] rng_state = 32'h939e_6001;
  data_t       model_bank [T][W];
  data_t       west_q [R][$];
  data_t       east_q [R][$];
  logic        in_reset_window;
  int          cycle_cnt;

  vc_tile_array u_vc_tile_array (.*);

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      $display("run took too many cycles, traffic did not drain");
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  end

  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  task automatic stop_on_error(string what);
    $display("%s", what);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic check_rsp(int t, ver_rsp_t got, data_t exp);
    if (!got.valid) begin
      stop_on_error($sformatf("load on tile %0d got no response", t));
    end else if (got.data !== exp) begin
      stop_on_error($sformatf("MISMATCH ver_rsp_o[%0d].data got %h expected %h",
                              t, got.data, exp));
    end
  endtask

  task automatic check_flit(int l, wh_link_t got, data_t exp);
    if (got.data !== exp) begin
      stop_on_error($sformatf("MISMATCH wh_east_o[%0d].data got %h expected %h",
                              l, got.data, exp));
    end
  endtask

  // one load per tile at addr, compared with the model bank
  task automatic check_word(bank_addr_t addr);
    for (int t = 0; t < T; t++) begin
      ver_req_i[t] = '{valid: 1'b1, we: 1'b0, addr: addr, data: '0};
    end
    @(negedge clk_i);
    ver_req_i = '0;
    for (int t = 0; t < T; t++) begin
      check_rsp(t, ver_rsp_o[t], model_bank[t][addr]);
    end
  endtask

  task automatic drive_west();
    for (int l = 0; l < R; l++) begin
      wh_west_i[l].valid = (west_q[l].size() > 0);
      wh_west_i[l].data  = (west_q[l].size() > 0) ? west_q[l][0] : '0;
    end
  endtask

  // sample handshakes just before the edge, check responses after it
  task automatic step();
    logic  exp_v [T];
    data_t exp_d [T];
    data_t exp_flit;
    #9;
    for (int l = 0; l < R; l++) begin
      if (wh_west_i[l].valid && wh_west_ready_o[l]) begin
        void'(west_q[l].pop_front());
      end
      if (wh_east_o[l].valid && in_reset_window) begin
        stop_on_error($sformatf("east channel %0d valid during reset", l));
      end
      if (wh_east_o[l].valid && wh_east_ready_i[l]) begin
        if (east_q[l].size() == 0) begin
          stop_on_error($sformatf("unexpected flit on east channel %0d", l));
        end else begin
          exp_flit = east_q[l].pop_front();
          check_flit(l, wh_east_o[l], exp_flit);
        end
      end
    end
    for (int t = 0; t < T; t++) begin
      exp_v[t] = 1'b0;
      exp_d[t] = '0;
      if (ver_req_i[t].valid && !in_reset_window) begin
        if (ver_req_i[t].we) begin
          model_bank[t][ver_req_i[t].addr] = ver_req_i[t].data;
        end else begin
          exp_v[t] = 1'b1;
          exp_d[t] = model_bank[t][ver_req_i[t].addr];
        end
      end
    end
    @(negedge clk_i);
    for (int t = 0; t < T; t++) begin
      if (exp_v[t]) begin
        check_rsp(t, ver_rsp_o[t], exp_d[t]);
      end else if (ver_rsp_o[t].valid) begin
        stop_on_error($sformatf("tile %0d gave a response with no load", t));
      end
    end
  endtask

  // west channel l owns tiles 2l and 2l+1, so bank order is per channel
  task automatic make_packet(int l, bit high_half);
    wh_header_t hdr;
    data_t      d;
    int         sel;
    int         east_l;
    sel      = int'(lcg_next() >> 30);
    hdr.pad  = '0;
    hdr.dest = cord_t'((sel >= 2 ? 4 : 0) + 2 * l + sel % 2);
    if (high_half) begin
      hdr.addr = bank_addr_t'(32'd8 + (lcg_next() >> 29));
      hdr.len  = len_t'(32'd1 + lcg_next() % (32'd16 - 32'(hdr.addr)));
    end else begin
      hdr.addr = bank_addr_t'(lcg_next() >> 28);
      hdr.len  = len_t'(32'd1 + lcg_next() % 32'd15);
    end
    east_l = (l + T) % R;
    west_q[l].push_back(data_t'(hdr));
    if (hdr.dest >= cord_t'(T)) begin
      east_q[east_l].push_back(data_t'(hdr));
    end
    for (int i = 0; i < int'(hdr.len); i++) begin
      d = lcg_next();
      west_q[l].push_back(d);
      if (hdr.dest < cord_t'(T)) begin
        model_bank[hdr.dest][bank_addr_t'(int'(hdr.addr) + i)] = d;
      end else begin
        east_q[east_l].push_back(d);
      end
    end
  endtask

  task automatic run_fills(bit with_stores);
    logic [31:0] r;
    for (int l = 0; l < R; l++) begin
      for (int p = 0; p < N_PKTS; p++) begin
        make_packet(l, with_stores);
      end
    end
    while (west_q[0].size() + west_q[1].size() + east_q[0].size() + east_q[1].size() > 0) begin
      drive_west();
      for (int l = 0; l < R; l++) begin
        r = lcg_next();
        wh_east_ready_i[l] = r[31];
      end
      for (int t = 0; t < T; t++) begin
        r = lcg_next();
        ver_req_i[t] = '{valid: with_stores && r[31], we: 1'b1,
                         addr: bank_addr_t'(r[26:24]), data: lcg_next()};
      end
      step();
    end
    // let consumed flits still in flight reach their banks
    drive_west();
    ver_req_i       = '0;
    wh_east_ready_i = '1;
    repeat (2 * T + 4) step();
  endtask

  initial begin
    logic [31:0] r;
    clk_i           = 1'b0;
    rst_n_i         = 1'b0;
    wh_west_i       = '0;
    wh_east_ready_i = '1;
    ver_req_i       = '0;
    in_reset_window = 1'b1;
    repeat (2) step();
    rst_n_i = 1'b1;
    // loads while the tiles still sit in reset
    for (int t = 0; t < T; t++) begin
      ver_req_i[t] = '{valid: 1'b1, we: 1'b0, addr: bank_addr_t'(lcg_next()), data: '0};
    end
    repeat (`VC_RESET_DEPTH) step();
    ver_req_i       = '0;
    in_reset_window = 1'b0;
    for (int a = 0; a < W; a++) begin
      for (int t = 0; t < T; t++) begin
        ver_req_i[t] = '{valid: 1'b1, we: 1'b1, addr: bank_addr_t'(a), data: lcg_next()};
      end
      step();
    end
    repeat (N_VER) begin
      for (int t = 0; t < T; t++) begin
        r = lcg_next();
        ver_req_i[t] = '{valid: r[31], we: r[30], addr: bank_addr_t'(r[27:24]),
                         data: lcg_next()};
      end
      step();
    end
    ver_req_i = '0;
    run_fills(1'b0);
    run_fills(1'b1);
    for (int a = 0; a < W; a++) begin
      check_word(bank_addr_t'(a));
    end
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// File: vc_consts.svh
// vcache strip constants
`ifndef VC_CONSTS_SVH
`define VC_CONSTS_SVH

// tiles in the row
`define VC_NUM_TILES 4

// wormhole channels per direction
`define VC_RUCHE_FACTOR 2

// words per bank, must equal 2**VC_ADDR_W
`define VC_BANK_WORDS 16

// word and flit width
`define VC_DATA_W 32

// destination x coordinate
`define VC_CORD_W 3

// data flits per packet
`define VC_LEN_W 4

// bank word address
`define VC_ADDR_W 4

// register stages in each tile reset path
`define VC_RESET_DEPTH 3

`endif

// File: vc_pkg.sv
// vcache strip types
`include "vc_consts.svh"

package vc_pkg;

  typedef logic [`VC_DATA_W-1:0] data_t;
  typedef logic [`VC_ADDR_W-1:0] bank_addr_t;
  typedef logic [`VC_CORD_W-1:0] cord_t;
  typedef logic [`VC_LEN_W-1:0]  len_t;

  // one wormhole link direction, ready travels separately
  typedef struct packed {
    logic  valid;
    data_t data;
  } wh_link_t;

  // header flit overlay, dest in the low bits
  typedef struct packed {
    logic [`VC_DATA_W-`VC_CORD_W-`VC_LEN_W-`VC_ADDR_W-1:0] pad;
    bank_addr_t                                           addr;
    len_t                                                 len;
    cord_t                                                dest;
  } wh_header_t;

  typedef struct packed {
    logic       valid;
    logic       we;
    bank_addr_t addr;
    data_t      data;
  } ver_req_t;

  typedef struct packed {
    logic  valid;
    data_t data;
  } ver_rsp_t;

  typedef enum logic [1:0] {
    chan_idle,
    chan_consume,
    chan_forward
  } chan_state_t;

endpackage

// File: vc_reset_chain.sv
// per-tile reset delay chain
`timescale 1ns/100ps
`include "vc_consts.svh"

module vc_reset_chain (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  output logic [`VC_NUM_TILES-1:0] tile_rst_n_o
);

  // separate copy per tile to spread the fanout
  for (genvar i = 0; i < `VC_NUM_TILES; i++) begin : g_tile
    logic [`VC_RESET_DEPTH-1:0] rst_sr_q;

    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        rst_sr_q <= '0;
      end else begin
        rst_sr_q <= {rst_sr_q[`VC_RESET_DEPTH-2:0], 1'b1};
      end
    end

    assign tile_rst_n_o[i] = rst_sr_q[`VC_RESET_DEPTH-1];
  end

endmodule

// File: vc_ruche_buffer.sv
// registered wormhole link stage
`timescale 1ns/100ps

module vc_ruche_buffer
  import vc_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  wh_link_t link_i,
  output logic     ready_o,
  output wh_link_t link_o,
  input  logic     ready_i
);

  logic  full_q;
  data_t data_q;

  // take a flit when empty or when the held one drains
  assign ready_o = !full_q || ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      full_q <= 1'b0;
    end else if (ready_o) begin
      full_q <= link_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ready_o && link_i.valid) begin
      data_q <= link_i.data;
    end
  end

  assign link_o.valid = full_q;
  assign link_o.data  = data_q;

endmodule

// File: vc_tile.sv
// vcache memory tile
`timescale 1ns/100ps
`include "vc_consts.svh"

module vc_tile
  import vc_pkg::*;
#(
  parameter cord_t X_CORD = '0
) (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  wh_link_t [`VC_RUCHE_FACTOR-1:0] wh_i,
  output logic     [`VC_RUCHE_FACTOR-1:0] wh_ready_o,
  output wh_link_t [`VC_RUCHE_FACTOR-1:0] wh_o,
  input  logic     [`VC_RUCHE_FACTOR-1:0] wh_ready_i,
  input  ver_req_t                        ver_req_i,
  output ver_rsp_t                        ver_rsp_o
);

  data_t bank_q [`VC_BANK_WORDS];

  logic  ver_store;
  logic  ver_load;
  logic  rsp_v_q;
  data_t rsp_data_q;

  logic [`VC_RUCHE_FACTOR-1:0] cons_req;
  logic [`VC_RUCHE_FACTOR-1:0] cons_free;
  logic [`VC_RUCHE_FACTOR-1:0] cons_gnt;
  bank_addr_t                  chan_addr [`VC_RUCHE_FACTOR];

  logic       wr_en;
  bank_addr_t wr_addr;
  data_t      wr_data;

  // stores are dropped while the tile is held in reset
  assign ver_store = rst_n_i && ver_req_i.valid && ver_req_i.we;
  assign ver_load  = ver_req_i.valid && !ver_req_i.we;

  // per-channel wormhole FSM
  for (genvar l = 0; l < `VC_RUCHE_FACTOR; l++) begin : g_chan
    chan_state_t state_q;
    len_t        cnt_q;
    bank_addr_t  addr_q;
    wh_header_t  hdr;
    logic        hdr_mine;
    logic        fwd;
    logic        xfer;

    assign hdr      = wh_header_t'(wh_i[l].data);
    assign hdr_mine = (hdr.dest == X_CORD);

    // header not for us goes straight through with the packet behind it
    assign fwd = (state_q == chan_forward) || ((state_q == chan_idle) && !hdr_mine);

    assign cons_req[l]  = (state_q == chan_consume) && wh_i[l].valid;
    assign chan_addr[l] = addr_q;

    // own header is always taken, it never needs the bank
    assign wh_ready_o[l] = (state_q == chan_consume) ? cons_free[l] :
                           (state_q == chan_forward) ? wh_ready_i[l] :
                           (hdr_mine || wh_ready_i[l]);

    assign wh_o[l].valid = fwd && wh_i[l].valid;
    assign wh_o[l].data  = wh_i[l].data;

    assign xfer = wh_i[l].valid && wh_ready_o[l];

    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        state_q <= chan_idle;
      end else if (xfer) begin
        case (state_q)
          chan_idle: begin
            if (hdr.len != '0) begin
              state_q <= hdr_mine ? chan_consume : chan_forward;
            end
          end
          default: begin
            if (cnt_q == len_t'(1)) begin
              state_q <= chan_idle;
            end
          end
        endcase
      end
    end

    // data flits left and next bank word
    always_ff @(posedge clk_i) begin
      if (xfer) begin
        if (state_q == chan_idle) begin
          cnt_q  <= hdr.len;
          addr_q <= hdr.addr;
        end else begin
          cnt_q  <= cnt_q - len_t'(1);
          addr_q <= addr_q + bank_addr_t'(1);
        end
      end
    end
  end

  // vertical store first, then lowest consuming channel
  always_comb begin
    logic taken;
    taken = ver_store;
    for (int l = 0; l < `VC_RUCHE_FACTOR; l++) begin
      cons_free[l] = !taken;
      cons_gnt[l]  = cons_req[l] && !taken;
      taken        = taken || cons_req[l];
    end
  end

  always_comb begin
    wr_en   = ver_store;
    wr_addr = ver_req_i.addr;
    wr_data = ver_req_i.data;
    for (int l = 0; l < `VC_RUCHE_FACTOR; l++) begin
      if (cons_gnt[l]) begin
        wr_en   = 1'b1;
        wr_addr = chan_addr[l];
        wr_data = wh_i[l].data;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      bank_q[wr_addr] <= wr_data;
    end
  end

  // load sees the bank before a same-cycle write
  always_ff @(posedge clk_i) begin
    if (ver_load) begin
      rsp_data_q <= bank_q[ver_req_i.addr];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rsp_v_q <= 1'b0;
    end else begin
      rsp_v_q <= ver_load;
    end
  end

  assign ver_rsp_o.valid = rsp_v_q;
  assign ver_rsp_o.data  = rsp_data_q;

endmodule

// File: vc_tile_array.sv
// vcache tile row
`timescale 1ns/100ps
`include "vc_consts.svh"

module vc_tile_array
  import vc_pkg::*;
(
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  wh_link_t [`VC_RUCHE_FACTOR-1:0] wh_west_i,
  output logic     [`VC_RUCHE_FACTOR-1:0] wh_west_ready_o,
  output wh_link_t [`VC_RUCHE_FACTOR-1:0] wh_east_o,
  input  logic     [`VC_RUCHE_FACTOR-1:0] wh_east_ready_i,
  input  ver_req_t [`VC_NUM_TILES-1:0]    ver_req_i,
  output ver_rsp_t [`VC_NUM_TILES-1:0]    ver_rsp_o
);

  logic [`VC_NUM_TILES-1:0] tile_rst_n;

  // stage c feeds tile c, the extra last stage is the east edge
  wh_link_t [`VC_RUCHE_FACTOR-1:0] stage_link  [`VC_NUM_TILES+1];
  logic     [`VC_RUCHE_FACTOR-1:0] stage_ready [`VC_NUM_TILES+1];

  // tile outputs into the buffers
  wh_link_t [`VC_RUCHE_FACTOR-1:0] tile_link  [`VC_NUM_TILES];
  logic     [`VC_RUCHE_FACTOR-1:0] tile_ready [`VC_NUM_TILES];

  vc_reset_chain u_reset_chain (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .tile_rst_n_o (tile_rst_n)
  );

  assign stage_link[0]                = wh_west_i;
  assign wh_west_ready_o              = stage_ready[0];
  assign wh_east_o                    = stage_link[`VC_NUM_TILES];
  assign stage_ready[`VC_NUM_TILES]   = wh_east_ready_i;

  for (genvar c = 0; c < `VC_NUM_TILES; c++) begin : g_tile
    vc_tile #(
      .X_CORD (cord_t'(c))
    ) u_tile (
      .clk_i      (clk_i),
      .rst_n_i    (tile_rst_n[c]),
      .wh_i       (stage_link[c]),
      .wh_ready_o (stage_ready[c]),
      .wh_o       (tile_link[c]),
      .wh_ready_i (tile_ready[c]),
      .ver_req_i  (ver_req_i[c]),
      .ver_rsp_o  (ver_rsp_o[c])
    );

    // channel index rotates by one per hop
    for (genvar l = 0; l < `VC_RUCHE_FACTOR; l++) begin : g_chan
      vc_ruche_buffer u_buf (
        .clk_i   (clk_i),
        .rst_n_i (tile_rst_n[c]),
        .link_i  (tile_link[c][l]),
        .ready_o (tile_ready[c][l]),
        .link_o  (stage_link[c+1][(l+1)%`VC_RUCHE_FACTOR]),
        .ready_i (stage_ready[c+1][(l+1)%`VC_RUCHE_FACTOR])
      );
    end
  end

endmodule

// File: vc_tile_array_asserts.sv
// tile row handshake checks
`timescale 1ns/100ps
`include "vc_consts.svh"

module vc_tile_array_asserts
  import vc_pkg::*;
(
  input logic                            clk_i,
  input logic                            rst_n_i,
  input wh_link_t [`VC_RUCHE_FACTOR-1:0] wh_east_o,
  input logic     [`VC_RUCHE_FACTOR-1:0] wh_east_ready_i,
  input ver_req_t [`VC_NUM_TILES-1:0]    ver_req_i,
  input ver_rsp_t [`VC_NUM_TILES-1:0]    ver_rsp_o
);

  int since_rst;

  // edges seen since rst_n_i went high, saturating
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      since_rst <= 0;
    end else if (since_rst <= `VC_RESET_DEPTH) begin
      since_rst <= since_rst + 1;
    end
  end

  for (genvar l = 0; l < `VC_RUCHE_FACTOR; l++) begin : g_east
    a_east_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      wh_east_o[l].valid && !wh_east_ready_i[l] |=>
        wh_east_o[l].valid && $stable(wh_east_o[l].data))
      else $error("stalled east flit changed on channel %0d", l);
  end

  for (genvar t = 0; t < `VC_NUM_TILES; t++) begin : g_rsp
    a_rsp_quiet: assert property (@(posedge clk_i)
      since_rst <= `VC_RESET_DEPTH |-> !ver_rsp_o[t].valid)
      else $error("response valid inside reset window on tile %0d", t);

    a_rsp_load: assert property (@(posedge clk_i)
      ver_rsp_o[t].valid |-> $past(ver_req_i[t].valid && !ver_req_i[t].we))
      else $error("response without a load on tile %0d", t);
  end

endmodule

bind vc_tile_array vc_tile_array_asserts u_asserts (.*);
